//--- Makefile
SIM        = verilator
TOP        = pdp8_mex_tb
FLIST      = pdp8_mex.f
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- major_state_seq.sv
module major_state_seq (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       tick,
  input  logic                       run,
  input  logic [0:11]                mdout,
  input  logic                       int_ena,
  input  logic                       int_inh,
  input  logic                       irq,
  output pdp8_mex_pkg::major_state_t state,
  output logic [0:11]                ir,
  output logic                       int_in_prog,
  output logic                       inst_done
);
  import pdp8_mex_pkg::*;

  major_state_t state_nxt;
  logic         last_phase;  // Current phase ends the instruction
  logic         mem_ref;
  logic         has_exec;
  logic         int_req;

  assign mem_ref  = (ir[0:2] <= OP_JMP);  // Opcodes 0..5
  assign has_exec = (ir[0:2] < OP_JMP);   // Opcodes 0..4 need E cycle

  // No nesting, the interrupt cycle itself must finish first
  assign int_req = int_ena && irq && !int_inh && !int_in_prog;

  always_comb begin
    state_nxt  = state;
    last_phase = 1'b0;
    case (state)
      F0: state_nxt = F1;
      F1: state_nxt = F2;
      F2: state_nxt = F3;
      F3: begin
        if (mem_ref && ir[3]) begin
          state_nxt = D0;
        end else if (has_exec) begin
          state_nxt = E0;
        end else begin
          last_phase = 1'b1;
        end
      end
      D0: state_nxt = DW;
      DW: state_nxt = D1;
      D1: state_nxt = D2;
      D2: state_nxt = D3;
      D3: begin
        if (has_exec) begin
          state_nxt = E0;
        end else begin
          last_phase = 1'b1;  // JMP indirect
        end
      end
      E0: state_nxt = E1;
      E1: state_nxt = E2;
      E2: state_nxt = E3;
      E3: last_phase = 1'b1;
      H0: state_nxt = H1;
      H1: state_nxt = H2;
      H2: state_nxt = H3;
      H3: if (run) state_nxt = F0;
      default: state_nxt = H0;
    endcase

    if (last_phase) begin
      if (int_req) begin
        state_nxt = E0;  // Interrupt cycle
      end else if (run) begin
        state_nxt = F0;
      end else begin
        state_nxt = H0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= H0;
      int_in_prog <= 1'b0;
      inst_done   <= 1'b0;
    end else begin
      inst_done <= 1'b0;
      if (tick) begin
        state <= state_nxt;
        // Strobe lands one clock after the ending tick
        inst_done <= last_phase && !int_req;
        if (last_phase) begin
          int_in_prog <= int_req;  // Set on entry, drops after E3
        end
      end
    end
  end

  // Interrupt cycle runs as a forced JMS 0
  always_ff @(posedge clk) begin
    if (tick && state == F0) begin
      ir <= mdout;
    end else if (tick && last_phase && int_req) begin
      ir <= {OP_JMS, 9'o000};
    end
  end

endmodule

//--- mem_cycle_timer.sv
module mem_cycle_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic run_en,
  output logic tick
);
  import pdp8_mex_pkg::*;

  logic [PHASE_CNT_W-1:0] cnt;

  // Last clock of the phase
  assign tick = run_en && (cnt == PHASE_CNT_W'(PHASE_TICKS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!run_en || tick) begin
      cnt <= '0;  // Idle core or phase boundary
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- mem_ext.sv
module mem_ext (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       tick,
  input  logic                       clear,
  input  logic                       extd_addrd,
  input  logic                       gtf,
  input  logic                       irq,
  input  logic                       int_in_prog,
  input  pdp8_mex_pkg::major_state_t state,
  input  logic [0:11]                ir,
  input  logic [0:11]                sr,
  input  logic [0:11]                ac,
  output logic                       int_ena,
  output logic                       int_inh,
  output logic                       mskip,
  output logic                       uf,  // User mode
  output logic                       ui,  // User trap pending
  output logic [0:2]                 dfld,
  output logic [0:2]                 ifld,
  output logic [0:11]                me_bus
);
  import pdp8_mex_pkg::*;

  logic [0:2] ib;  // Instruction field buffer
  logic       ub;  // User buffer
  logic [0:6] savereg;  // {uf, ifld, dfld} at interrupt
  logic       int_delay;
  logic       opr_priv;
  logic       field_iot;
  logic       xfer;

  // HLT, OSR, LAS in group 2 operate
  assign opr_priv = (ir[0:3] == {OP_OPR, 1'b1}) && !ir[11] && (ir[9:10] != 2'b00);

  // 62N1 CDF, 62N2 CIF, 62N3 both
  assign field_iot = (ir[0:5] == IOT_FIELD_GRP) && !ir[9] && (ir[10:11] != 2'b00);

  // Buffered fields move on the next jump
  assign xfer = int_inh &&
                (((state == F2) && (ir[0:3] == {OP_JMP, 1'b0})) ||
                 ((state == DW) && (ir[0:3] == JMPI)) ||
                 ((state == E2) && (ir[0:2] == OP_JMS)));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      savereg   <= '0;
      ifld      <= '0;
      ib        <= '0;
      dfld      <= '0;
      uf        <= 1'b0;
      ub        <= 1'b0;
      ui        <= 1'b0;
      int_inh   <= 1'b0;
      int_ena   <= 1'b0;
      int_delay <= 1'b0;
      mskip     <= 1'b0;
      me_bus    <= '0;
    end else if (clear) begin
      savereg   <= '0;
      ifld      <= '0;
      ib        <= '0;
      dfld      <= '0;
      uf        <= 1'b0;
      ub        <= 1'b0;
      ui        <= 1'b0;
      int_inh   <= 1'b0;
      int_ena   <= 1'b0;
      int_delay <= 1'b0;
      mskip     <= 1'b0;
    end else if (tick) begin
      case (state)
        F1: begin
          case (ir)
            SRQ:  if (!uf && irq) mskip <= 1'b1;
            SGT:  if (gtf) mskip <= 1'b1;
            SKON: if (!uf && int_ena) mskip <= 1'b1;
            SINT: if (!uf && ui) mskip <= 1'b1;
            default: ;
          endcase
        end

        F2: begin
          if (!uf) begin
            case (ir)
              GTF: me_bus <= {1'b0, gtf, irq, int_inh, int_ena | int_delay, savereg};
              CUI: ui <= 1'b0;
              RDF: me_bus <= ac | {6'o00, dfld, 3'o0};
              RIF: me_bus <= ac | {6'o00, ifld, 3'o0};
              RIB: me_bus <= ac | {5'b00000, savereg};
              default: ;
            endcase
          end
          if (uf && (opr_priv || ir[0:2] == OP_IOT)) begin
            ui <= 1'b1;  // Trap privileged op
          end
          if (int_delay) begin
            int_ena   <= 1'b1;  // ION takes effect here
            int_delay <= 1'b0;
          end
        end

        F3: begin
          if (!uf) begin
            case (ir)
              SKON, IOF: begin
                int_ena   <= 1'b0;
                int_delay <= 1'b0;
              end
              ION: int_delay <= 1'b1;
              RTF: begin
                {ub, ib, dfld} <= ac[5:11];
                int_delay      <= 1'b1;
                int_inh        <= 1'b1;
              end
              CAF: begin
                int_ena   <= 1'b0;
                int_delay <= 1'b0;
                ui        <= 1'b0;
              end
              RMF: begin
                ub      <= savereg[0];
                ib      <= savereg[1:3];
                dfld    <= savereg[4:6];
                int_inh <= 1'b1;
              end
              CUF: ub <= 1'b0;
              SUF: begin
                ub      <= 1'b1;
                int_inh <= 1'b1;
              end
              default: begin
                if (field_iot) begin
                  if (ir[11]) dfld <= ir[6:8];  // Data field now
                  if (ir[10]) begin
                    ib      <= ir[6:8];  // Waits for jump
                    int_inh <= 1'b1;
                  end
                end
              end
            endcase
          end
          mskip <= 1'b0;
        end

        E0: begin
          if (int_in_prog) begin
            savereg   <= {uf, ifld, dfld};
            ifld      <= '0;
            dfld      <= '0;
            uf        <= 1'b0;
            ub        <= 1'b0;
            int_ena   <= 1'b0;
            int_delay <= 1'b0;
          end
        end

        H1: begin
          if (extd_addrd) begin
            ifld <= sr[6:8];  // Load from switches
            ib   <= sr[6:8];
            dfld <= sr[9:11];
            uf   <= 1'b0;
            ub   <= 1'b0;
          end
        end

        default: ;
      endcase

      if (xfer) begin
        ifld    <= ib;
        uf      <= ub;
        int_inh <= 1'b0;
      end
    end
  end

endmodule

//--- pdp8_mex.f
pdp8_mex_pkg.sv
mem_cycle_timer.sv
major_state_seq.sv
mem_ext.sv
pdp8_mex.sv
pdp8_mex_chk.sv
pdp8_mex_tb.sv

//--- pdp8_mex.sv
module pdp8_mex (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       run,
  input  logic                       clear,
  input  logic                       extd_addrd,
  input  logic                       gtf,
  input  logic                       irq,
  input  logic [0:11]                mdout,
  input  logic [0:11]                sr,
  input  logic [0:11]                ac,
  output pdp8_mex_pkg::major_state_t state,
  output logic                       int_in_prog,
  output logic                       inst_done,
  output logic                       int_ena,
  output logic                       int_inh,
  output logic                       mskip,
  output logic                       uf,
  output logic                       ui,
  output logic [0:2]                 dfld,
  output logic [0:2]                 ifld,
  output logic [0:11]                me_bus
);
  import pdp8_mex_pkg::*;

  logic        tick;
  logic        run_en;
  logic [0:11] ir;

  // Core stops only when parked in H3 without run
  assign run_en = (state != H3) || run;

  mem_cycle_timer u_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .run_en(run_en),
    .tick  (tick)
  );

  major_state_seq u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .tick       (tick),
    .run        (run),
    .mdout      (mdout),
    .int_ena    (int_ena),
    .int_inh    (int_inh),
    .irq        (irq),
    .state      (state),
    .ir         (ir),
    .int_in_prog(int_in_prog),
    .inst_done  (inst_done)
  );

  mem_ext u_mem_ext (
    .clk        (clk),
    .rst_n      (rst_n),
    .tick       (tick),
    .clear      (clear),
    .extd_addrd (extd_addrd),
    .gtf        (gtf),
    .irq        (irq),
    .int_in_prog(int_in_prog),
    .state      (state),
    .ir         (ir),
    .sr         (sr),
    .ac         (ac),
    .int_ena    (int_ena),
    .int_inh    (int_inh),
    .mskip      (mskip),
    .uf         (uf),
    .ui         (ui),
    .dfld       (dfld),
    .ifld       (ifld),
    .me_bus     (me_bus)
  );

endmodule

//--- pdp8_mex_chk.sv
module pdp8_mex_chk (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       clear,
  input pdp8_mex_pkg::major_state_t state,
  input logic [0:11]                ir,
  input logic                       mskip,
  input logic [0:2]                 ifld,
  input logic                       int_ena
);
  timeunit 1ns;
  timeprecision 100ps;
  import pdp8_mex_pkg::*;

  // Skip request lives only in F2 and F3
  mskip_window: assert property (@(posedge clk) disable iff (!rst_n)
    (state != F2 && state != F3) |-> !mskip)
    else $error("mskip high outside F2..F3");

  // Field moves on jumps, interrupt entry and switch load
  ifld_change: assert property (@(posedge clk) disable iff (!rst_n)
    (ifld != $past(ifld)) |->
      ($past(clear) || $past(state) == F2 || $past(state) == DW ||
       $past(state) == E0 || $past(state) == E2 || $past(state) == H1))
    else $error("ifld changed in phase %0d", $past(state));

  // ION executes in F3, the enable follows one instruction later
  ion_delay: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(int_ena) |-> !($past(state) == F3 && $past(ir) == ION))
    else $error("int_ena rose during ION");

endmodule

bind mem_ext pdp8_mex_chk chk0 (
  .clk    (clk),
  .rst_n  (rst_n),
  .clear  (clear),
  .state  (state),
  .ir     (ir),
  .mskip  (mskip),
  .ifld   (ifld),
  .int_ena(int_ena)
);

//--- pdp8_mex_pkg.sv
package pdp8_mex_pkg;

  // Major states of the processor
  typedef enum logic [4:0] {
    F0,
    F1,
    F2,
    F3,
    D0,
    DW,  // Defer wait, pointer read settles
    D1,
    D2,
    D3,
    E0,
    E1,
    E2,
    E3,
    H0,
    H1,
    H2,
    H3
  } major_state_t;

  // IOT words decoded by the memory extension
  typedef enum logic [0:11] {
    SKON = 12'o6000,
    ION  = 12'o6001,
    IOF  = 12'o6002,
    SRQ  = 12'o6003,
    GTF  = 12'o6004,
    RTF  = 12'o6005,
    SGT  = 12'o6006,
    CAF  = 12'o6007,
    CUI  = 12'o6204,
    RDF  = 12'o6214,
    RIF  = 12'o6224,
    RIB  = 12'o6234,
    RMF  = 12'o6244,
    SINT = 12'o6254,
    CUF  = 12'o6264,
    SUF  = 12'o6274
  } iot_op_t;

  localparam logic [0:5] IOT_FIELD_GRP = 6'o62;  // CDF and CIF group 62N1..62N3

  localparam logic [0:2] OP_JMS = 3'o4;
  localparam logic [0:2] OP_JMP = 3'o5;
  localparam logic [0:2] OP_IOT = 3'o6;
  localparam logic [0:2] OP_OPR = 3'o7;

  localparam logic [0:3] JMPI = 4'b1011;  // JMP with indirect bit

  localparam int PHASE_TICKS = 2;  // Clocks per memory phase
  localparam int PHASE_CNT_W = (PHASE_TICKS > 1) ? $clog2(PHASE_TICKS) : 1;

endpackage

//--- pdp8_mex_tb.sv
module pdp8_mex_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import pdp8_mex_pkg::*;

  typedef struct packed {
    logic [0:11] md;
    logic [0:11] ac;
    logic [0:11] sr;
    logic        irq;
    logic        run;
    logic        ext;
    logic        clr;
    logic [2:0]  d;
    logic [2:0]  i;
    logic        u;
    logic        ui;
    logic        ie;
    logic        inh;
    logic        sk;
    logic        intr;
    logic [11:0] bus;
    logic [11:0] mask;
  } row_t;

  localparam int NUM_ROWS = 31;
  localparam longint WATCHDOG_NS = (NUM_ROWS * 13 + 24) * PHASE_TICKS * 40 + 2000;

  logic         clk;
  logic         rst_n;
  logic         run;
  logic         clear;
  logic         extd_addrd;
  logic         gtf;
  logic         irq;
  logic [0:11]  mdout;
  logic [0:11]  sr;
  logic [0:11]  ac;
  major_state_t state;
  logic         int_in_prog;
  logic         inst_done;
  logic         int_ena;
  logic         int_inh;
  logic         mskip;
  logic         uf;
  logic         ui;
  logic [0:2]   dfld;
  logic [0:2]   ifld;
  logic [0:11]  me_bus;
  int           skip_count;
  int           intr_count;
  row_t         rows[$];

  pdp8_mex dut0 (.*);

  always #20 clk = ~clk;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      skip_count <= 0;
      intr_count <= 0;
    end else begin
      if (mskip) skip_count <= skip_count + 1;  // Skip seen this row
      if (int_in_prog) intr_count <= intr_count + 1;  // Interrupt cycle running
    end
  end

  task automatic add_row(input logic [0:11] md, input logic [0:11] acc, input logic rq,
                         input logic [2:0] d, input logic [2:0] i, input logic u,
                         input logic t, input logic ie, input logic inh, input logic sk,
                         input logic [11:0] bus, input logic [11:0] mask);
    row_t r;
    r = '{md, acc, 12'o0000, rq, 1'b1, 1'b0, 1'b0, d, i, u, t, ie, inh, sk, 1'b0, bus, mask};
    rows.push_back(r);
  endtask

  task automatic check_value(input string name, input logic [11:0] got,
                             input logic [11:0] expected, input logic [11:0] mask);
    if (((got ^ expected) & mask) != 12'o0000) begin
      $display("[ERROR] %0t ns: %s is %o, expected %o", $time, name, got, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_clock();
    @(posedge clk);
    #2;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the DUT hung waiting for an instruction to end");
    $display("*** TEST FAILED ***");
    $fatal(1, "timeout");
  end

  initial begin
    int   start;
    int   intr_start;
    row_t r;
    clk        = 1'b0;
    rst_n      = 1'b0;
    run        = 1'b1;
    clear      = 1'b0;
    extd_addrd = 1'b0;
    gtf        = 1'b0;
    irq        = 1'b0;
    mdout      = 12'o7000;
    sr         = 12'o0000;
    ac         = 12'o0000;

    //      mdout     ac        irq d  i  u  ui ie ih sk bus       mask
    add_row(12'o6211, 12'o0000, 0, 1, 0, 0, 0, 0, 0, 0, 12'o0000, 12'o0000);  // CDF 1
    add_row(12'o6222, 12'o0000, 0, 1, 0, 0, 0, 0, 1, 0, 12'o0000, 12'o0000);  // CIF 2
    add_row(12'o5000, 12'o0000, 0, 1, 2, 0, 0, 0, 0, 0, 12'o0000, 12'o0000);  // JMP
    add_row(12'o6001, 12'o0000, 0, 1, 2, 0, 0, 0, 0, 0, 12'o0000, 12'o0000);  // ION
    add_row(12'o7000, 12'o0000, 0, 1, 2, 0, 0, 1, 0, 0, 12'o0000, 12'o0000);
    add_row(12'o6000, 12'o0000, 0, 1, 2, 0, 0, 0, 0, 1, 12'o0000, 12'o0000);  // SKON
    add_row(12'o6001, 12'o0000, 0, 1, 2, 0, 0, 0, 0, 0, 12'o0000, 12'o0000);
    add_row(12'o7000, 12'o0000, 0, 1, 2, 0, 0, 1, 0, 0, 12'o0000, 12'o0000);
    add_row(12'o6002, 12'o0000, 0, 1, 2, 0, 0, 0, 0, 0, 12'o0000, 12'o0000);  // IOF
    add_row(12'o6001, 12'o0000, 0, 1, 2, 0, 0, 0, 0, 0, 12'o0000, 12'o0000);
    add_row(12'o7000, 12'o0000, 0, 1, 2, 0, 0, 1, 0, 0, 12'o0000, 12'o0000);
    add_row(12'o7000, 12'o0000, 1, 0, 0, 0, 0, 0, 0, 0, 12'o0000, 12'o0000);  // Interrupt
    rows[rows.size() - 1].intr = 1'b1;
    add_row(12'o6234, 12'o0000, 0, 0, 0, 0, 0, 0, 0, 0, 12'o0021, 12'o7777);  // RIB
    add_row(12'o6244, 12'o0000, 0, 1, 0, 0, 0, 0, 1, 0, 12'o0000, 12'o0000);  // RMF
    add_row(12'o5000, 12'o0000, 0, 1, 2, 0, 0, 0, 0, 0, 12'o0000, 12'o0000);
    add_row(12'o6001, 12'o0000, 0, 1, 2, 0, 0, 0, 0, 0, 12'o0000, 12'o0000);
    add_row(12'o6274, 12'o0000, 0, 1, 2, 0, 0, 1, 1, 0, 12'o0000, 12'o0000);  // SUF
    add_row(12'o5000, 12'o0000, 0, 1, 2, 1, 0, 1, 0, 0, 12'o0000, 12'o0000);
    add_row(12'o6000, 12'o0000, 0, 1, 2, 1, 1, 1, 0, 0, 12'o0000, 12'o0000);  // User SKON
    add_row(12'o6231, 12'o0000, 0, 1, 2, 1, 1, 1, 0, 0, 12'o0000, 12'o0000);  // User CDF
    add_row(12'o6003, 12'o0000, 1, 0, 0, 0, 1, 0, 0, 0, 12'o0000, 12'o0000);  // SRQ, irq
    rows[rows.size() - 1].intr = 1'b1;
    add_row(12'o6204, 12'o0000, 0, 0, 0, 0, 0, 0, 0, 0, 12'o0000, 12'o0000);  // CUI
    add_row(12'o6274, 12'o0000, 0, 0, 0, 0, 0, 0, 1, 0, 12'o0000, 12'o0000);
    add_row(12'o5000, 12'o0000, 0, 0, 2, 1, 0, 0, 0, 0, 12'o0000, 12'o0000);
    add_row(12'o7402, 12'o0000, 0, 0, 2, 1, 1, 0, 0, 0, 12'o0000, 12'o0000);  // User HLT
    add_row(12'o7000, 12'o0000, 0, 5, 3, 0, 1, 0, 0, 0, 12'o0000, 12'o0000);  // Halt
    rows[rows.size() - 1].run = 1'b0;
    rows[rows.size() - 1].ext = 1'b1;
    rows[rows.size() - 1].sr  = 12'o0035;
    add_row(12'o6234, 12'o7700, 0, 5, 3, 0, 1, 0, 0, 0, 12'o7721, 12'o7777);
    add_row(12'o7000, 12'o0000, 0, 0, 0, 0, 0, 0, 0, 0, 12'o0000, 12'o0000);  // Clear
    rows[rows.size() - 1].clr = 1'b1;
    add_row(12'o6273, 12'o0000, 0, 7, 0, 0, 0, 0, 1, 0, 12'o0000, 12'o0000);  // CDF CIF 7
    add_row(12'o5000, 12'o0000, 0, 7, 7, 0, 0, 0, 0, 0, 12'o0000, 12'o0000);
    add_row(12'o6274, 12'o0000, 0, 7, 7, 0, 0, 0, 1, 0, 12'o0000, 12'o0000);  // SUF

    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    foreach (rows[n]) begin
      r          = rows[n];
      mdout      = r.md;
      ac         = r.ac;
      sr         = r.sr;
      irq        = r.irq;
      run        = r.run;
      extd_addrd = r.ext;
      clear      = r.clr;
      start      = skip_count;
      intr_start = intr_count;
      if (r.clr) begin
        wait_clock();
        clear = 1'b0;
      end
      if (!r.run) begin
        do wait_clock(); while (state != H3);  // Parked in halt
      end else begin
        do wait_clock(); while (!inst_done);
      end
      check_value($sformatf("row %0d dfld", n), 12'(dfld), 12'(r.d), 12'o7777);
      check_value($sformatf("row %0d ifld", n), 12'(ifld), 12'(r.i), 12'o7777);
      check_value($sformatf("row %0d uf", n), 12'(uf), 12'(r.u), 12'o7777);
      check_value($sformatf("row %0d ui", n), 12'(ui), 12'(r.ui), 12'o7777);
      check_value($sformatf("row %0d int_ena", n), 12'(int_ena), 12'(r.ie), 12'o7777);
      check_value($sformatf("row %0d int_inh", n), 12'(int_inh), 12'(r.inh), 12'o7777);
      check_value($sformatf("row %0d skip", n), 12'(skip_count != start), 12'(r.sk),
                  12'o7777);
      check_value($sformatf("row %0d int cycle", n), 12'(intr_count != intr_start),
                  12'(r.intr), 12'o7777);
      check_value($sformatf("row %0d me_bus", n), me_bus, r.bus, r.mask);
    end

    rst_n = 1'b0;  // Reset clears everything again
    repeat (3) @(posedge clk);
    #2;
    check_value("reset state", 12'(state), 12'(H0), 12'o7777);
    check_value("reset dfld", 12'(dfld), 12'o0000, 12'o7777);
    check_value("reset ifld", 12'(ifld), 12'o0000, 12'o7777);
    check_value("reset flags", {uf, ui, int_ena, int_inh, mskip, inst_done, int_in_prog},
                12'o0000, 12'o7777);
    check_value("reset me_bus", me_bus, 12'o0000, 12'o7777);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
